// ==== source/mci_boot_pkg.sv ====
`default_nettype none

package mci_boot_pkg;

  ////////////////////////////////////////////////////////////
  // Sequencer sizing
  ////////////////////////////////////////////////////////////

  // Width of the encoded boot state
  localparam int unsigned STATE_W = 4;

  // MCU held in reset for at least 2**MIN_RST_CNT_W cycles
  localparam int unsigned MIN_RST_CNT_W = 4;

  ////////////////////////////////////////////////////////////
  // Boot FSM encoding
  ////////////////////////////////////////////////////////////

  typedef enum logic [STATE_W-1:0] {
    IDLE             = 4'h0,
    OTP_FC           = 4'h1,
    LCC              = 4'h2,
    BREAKPOINT       = 4'h3,
    MCU              = 4'h4,
    WAIT_CPTRA_GO    = 4'h5,
    CPTRA            = 4'h6,
    WAIT_MCU_RST_REQ = 4'h7,
    RST_MCU          = 4'h8,
    // Landing point for any illegal encoding
    UNKNOWN          = 4'hF
  } boot_state_e;

  ////////////////////////////////////////////////////////////
  // Status seen by the register block
  ////////////////////////////////////////////////////////////

  // Field order matches the BOOT_STATUS register layout, LSB last
  typedef struct packed {
    logic        fw_hitless_upd;  // Later MCU reset requests
    logic        fw_boot_upd;     // First MCU reset request
    logic        mcu_reset_once;  // Sticky, MCU has been reset by firmware
    boot_state_e state;
  } boot_status_t;

endpackage

`default_nettype wire

// ==== source/mci_reg_pkg.sv ====
`default_nettype none

package mci_reg_pkg;

  ////////////////////////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////////////////////////

  localparam int unsigned REG_AW = 4;
  localparam int unsigned REG_DW = 32;

  // Request beat
  typedef struct packed {
    logic              write;
    logic [REG_AW-1:0] addr;
    logic [REG_DW-1:0] wdata;
  } reg_req_t;

  // Response beat
  typedef struct packed {
    logic [REG_DW-1:0] rdata;
    logic              err;   // Unmapped address
  } reg_rsp_t;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  localparam logic [REG_AW-1:0] ADDR_FW_EXEC_CTRL = 4'h0;
  localparam logic [REG_AW-1:0] ADDR_RESET_REQ    = 4'h4;
  localparam logic [REG_AW-1:0] ADDR_BOOT_STATUS  = 4'h8;

  // FW_EXEC_CTRL fields
  localparam int unsigned FW_EXEC_LOCK_BIT = 0;

  // RESET_REQ fields, write 1 to trigger
  localparam int unsigned RESET_REQ_BIT = 0;

  // BOOT_STATUS fields
  localparam int unsigned STATUS_STATE_LSB      = 0;
  localparam int unsigned STATUS_RESET_ONCE_BIT = 4;
  localparam int unsigned STATUS_BOOT_UPD_BIT   = 5;
  localparam int unsigned STATUS_HITLESS_BIT    = 6;

endpackage

`default_nettype wire

// ==== source/mci_boot_seqr.sv ====
`default_nettype none

module mci_boot_seqr #(
  // Minimum MCU reset time is 2**RST_CNT_W cycles
  parameter int unsigned RST_CNT_W = mci_boot_pkg::MIN_RST_CNT_W
) (
  input  logic                      clk,
  input  logic                      mci_rst_b,

  // SoC handshakes, all asynchronous
  input  logic                      fc_done_i,
  input  logic                      lc_done_i,
  input  logic                      brkpoint_i,
  input  logic                      cptra_boot_go_i,

  // From the register block
  input  logic                      rst_req_i,
  input  logic                      region_lock_i,

  // Init requests, sticky once set
  output logic                      fc_init_o,
  output logic                      lc_init_o,

  // Reset releases
  output logic                      mcu_rst_b_o,
  output logic                      cptra_rst_b_o,

  output mci_boot_pkg::boot_status_t status_o
);

  // Inputs that cross into the local clock domain
  typedef struct packed {
    logic fc_done;
    logic lc_done;
    logic brkpoint;
    logic cptra_boot_go;
  } sync_t;

  sync_t sync_meta;
  sync_t sync_q;

  mci_boot_pkg::boot_state_e state_q;
  mci_boot_pkg::boot_state_e state_d;
  mci_boot_pkg::boot_state_e prev_q;

  logic fc_init_q;
  logic fc_init_d;
  logic lc_init_q;
  logic lc_init_d;
  logic mcu_rst_b_q;
  logic mcu_rst_b_d;
  logic cptra_rst_b_q;
  logic cptra_rst_b_d;

  // Reset reason flags
  logic reset_once_q;
  logic reset_once_d;
  logic boot_upd_q;
  logic boot_upd_d;
  logic hitless_upd_q;
  logic hitless_upd_d;

  // Minimum reset timer
  logic [RST_CNT_W-1:0] rst_cnt_q;
  logic [RST_CNT_W-1:0] rst_cnt_d;
  logic                 rst_elapsed_q;
  logic                 rst_elapsed_d;

  ////////////////////////////////////////////////////////////
  // Synchronizers
  ////////////////////////////////////////////////////////////

  // Two flop stages per input
  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      sync_meta <= '0;
      sync_q    <= '0;
    end else begin
      sync_meta.fc_done       <= fc_done_i;
      sync_meta.lc_done       <= lc_done_i;
      sync_meta.brkpoint      <= brkpoint_i;
      sync_meta.cptra_boot_go <= cptra_boot_go_i;
      sync_q                  <= sync_meta;
    end
  end

  ////////////////////////////////////////////////////////////
  // Boot FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      state_q       <= mci_boot_pkg::IDLE;
      prev_q        <= mci_boot_pkg::IDLE;
      fc_init_q     <= 1'b0;
      lc_init_q     <= 1'b0;
      mcu_rst_b_q   <= 1'b0;
      cptra_rst_b_q <= 1'b0;
      reset_once_q  <= 1'b0;
      boot_upd_q    <= 1'b0;
      hitless_upd_q <= 1'b0;
      rst_cnt_q     <= '0;
      rst_elapsed_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      // Remember where we came from on every real transition
      if (state_d != state_q) begin
        prev_q <= state_q;
      end
      fc_init_q     <= fc_init_d;
      lc_init_q     <= lc_init_d;
      mcu_rst_b_q   <= mcu_rst_b_d;
      cptra_rst_b_q <= cptra_rst_b_d;
      reset_once_q  <= reset_once_d;
      boot_upd_q    <= boot_upd_d;
      hitless_upd_q <= hitless_upd_d;
      rst_cnt_q     <= rst_cnt_d;
      rst_elapsed_q <= rst_elapsed_d;
    end
  end

  always_comb begin
    state_d       = state_q;
    fc_init_d     = fc_init_q;
    lc_init_d     = lc_init_q;
    mcu_rst_b_d   = mcu_rst_b_q;
    cptra_rst_b_d = cptra_rst_b_q;
    reset_once_d  = reset_once_q;
    boot_upd_d    = boot_upd_q;
    hitless_upd_d = hitless_upd_q;
    case (state_q)
      // Only entered through mci_rst_b
      mci_boot_pkg::IDLE: begin
        state_d = mci_boot_pkg::OTP_FC;
      end
      mci_boot_pkg::OTP_FC: begin
        fc_init_d = 1'b1;
        if (sync_q.fc_done) begin
          state_d = mci_boot_pkg::LCC;
        end
      end
      mci_boot_pkg::LCC: begin
        lc_init_d = 1'b1;
        if (sync_q.lc_done) begin
          state_d = mci_boot_pkg::BREAKPOINT;
        end
      end
      // Debug hold before MCU release
      mci_boot_pkg::BREAKPOINT: begin
        if (!sync_q.brkpoint) begin
          state_d = mci_boot_pkg::MCU;
        end
      end
      mci_boot_pkg::MCU: begin
        mcu_rst_b_d = 1'b1;
        // After a firmware reset, skip the wait for boot-go
        if (prev_q == mci_boot_pkg::RST_MCU) begin
          state_d = mci_boot_pkg::WAIT_MCU_RST_REQ;
        end else begin
          state_d = mci_boot_pkg::WAIT_CPTRA_GO;
        end
      end
      mci_boot_pkg::WAIT_CPTRA_GO: begin
        if (sync_q.cptra_boot_go) begin
          state_d = mci_boot_pkg::CPTRA;
        end
      end
      mci_boot_pkg::CPTRA: begin
        cptra_rst_b_d = 1'b1;
        state_d       = mci_boot_pkg::WAIT_MCU_RST_REQ;
      end
      mci_boot_pkg::WAIT_MCU_RST_REQ: begin
        if (rst_req_i) begin
          state_d       = mci_boot_pkg::RST_MCU;
          // First request is a boot update, the rest are hitless
          boot_upd_d    = !reset_once_q;
          hitless_upd_d = reset_once_q;
        end
      end
      mci_boot_pkg::RST_MCU: begin
        mcu_rst_b_d  = 1'b0;
        reset_once_d = 1'b1;
        // Release once held long enough and the new image is locked
        if (rst_elapsed_q && region_lock_i) begin
          state_d = mci_boot_pkg::MCU;
        end
      end
      default: begin
        state_d = mci_boot_pkg::UNKNOWN;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Minimum MCU reset timer
  ////////////////////////////////////////////////////////////

  always_comb begin
    rst_cnt_d     = rst_cnt_q;
    rst_elapsed_d = rst_elapsed_q;
    // Restart on entry to RST_MCU
    if (state_d == mci_boot_pkg::RST_MCU && state_q != mci_boot_pkg::RST_MCU) begin
      rst_cnt_d     = '0;
      rst_elapsed_d = 1'b0;
    end else if (state_q == mci_boot_pkg::RST_MCU) begin
      // Saturate at all ones, flag on the following cycle
      if (rst_cnt_q != '1) begin
        rst_cnt_d = rst_cnt_q + RST_CNT_W'(1);
      end else begin
        rst_elapsed_d = 1'b1;
      end
    end
  end

  // Outputs
  assign fc_init_o     = fc_init_q;
  assign lc_init_o     = lc_init_q;
  assign mcu_rst_b_o   = mcu_rst_b_q;
  assign cptra_rst_b_o = cptra_rst_b_q;

  assign status_o.state          = state_q;
  assign status_o.mcu_reset_once = reset_once_q;
  assign status_o.fw_boot_upd    = boot_upd_q;
  assign status_o.fw_hitless_upd = hitless_upd_q;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // FSM never drops into an illegal encoding
  a_state_legal: assert property (@(posedge clk) disable iff (!mci_rst_b)
    !$isunknown(state_q) && state_q != mci_boot_pkg::UNKNOWN)
    else $error("boot FSM in illegal state");

  // Core released only behind the MCU on first boot
  a_cptra_after_mcu: assert property (@(posedge clk) disable iff (!mci_rst_b)
    $rose(cptra_rst_b_q) |-> mcu_rst_b_q && !reset_once_q)
    else $error("cptra_rst_b rose while MCU in reset");

  // Reset reason is one or the other
  a_reason_onehot: assert property (@(posedge clk) disable iff (!mci_rst_b)
    !(boot_upd_q && hitless_upd_q))
    else $error("boot and hitless update flags both set");

endmodule

`default_nettype wire

// ==== source/mci_boot_regs.sv ====
`default_nettype none

module mci_boot_regs (
  input  logic                       clk,
  input  logic                       mci_rst_b,

  // Request channel
  input  logic                       req_valid_i,
  input  mci_reg_pkg::reg_req_t      req_i,
  output logic                       req_ready_o,

  // Response channel
  output logic                       rsp_valid_o,
  output mci_reg_pkg::reg_rsp_t      rsp_o,
  input  logic                       rsp_ready_i,

  // Sequencer side
  input  mci_boot_pkg::boot_status_t status_i,
  output logic                       region_lock_o,
  output logic                       rst_req_o
);

  logic req_fire;
  logic rsp_fire;

  logic req_ready_q;
  logic rsp_valid_q;

  mci_reg_pkg::reg_rsp_t rsp_d;
  mci_reg_pkg::reg_rsp_t rsp_q;

  logic region_lock_q;
  logic rst_req_q;

  // Handshakes
  assign req_fire = req_valid_i && req_ready_q;
  assign rsp_fire = rsp_valid_q && rsp_ready_i;

  ////////////////////////////////////////////////////////////
  // Handshake control
  ////////////////////////////////////////////////////////////

  // One outstanding request, ready returns once the response is taken
  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      req_ready_q <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      req_ready_q <= !req_fire && (!rsp_valid_q || rsp_fire);
      if (req_fire) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_fire) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    rsp_d = '0;
    case (req_i.addr)
      mci_reg_pkg::ADDR_FW_EXEC_CTRL: begin
        rsp_d.rdata[mci_reg_pkg::FW_EXEC_LOCK_BIT] = region_lock_q;
      end
      // Trigger register, always reads zero
      mci_reg_pkg::ADDR_RESET_REQ: begin
        rsp_d.rdata = '0;
      end
      mci_reg_pkg::ADDR_BOOT_STATUS: begin
        rsp_d.rdata[mci_reg_pkg::STATUS_STATE_LSB +: mci_boot_pkg::STATE_W] = status_i.state;
        rsp_d.rdata[mci_reg_pkg::STATUS_RESET_ONCE_BIT] = status_i.mcu_reset_once;
        rsp_d.rdata[mci_reg_pkg::STATUS_BOOT_UPD_BIT]   = status_i.fw_boot_upd;
        rsp_d.rdata[mci_reg_pkg::STATUS_HITLESS_BIT]    = status_i.fw_hitless_upd;
      end
      default: begin
        rsp_d.err = 1'b1;
      end
    endcase
    // Writes return no data
    if (req_i.write) begin
      rsp_d.rdata = '0;
    end
  end

  // Response held under back-pressure
  always_ff @(posedge clk) begin
    if (req_fire) begin
      rsp_q <= rsp_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      region_lock_q <= 1'b0;
      rst_req_q     <= 1'b0;
    end else begin
      if (req_fire && req_i.write && req_i.addr == mci_reg_pkg::ADDR_FW_EXEC_CTRL) begin
        region_lock_q <= req_i.wdata[mci_reg_pkg::FW_EXEC_LOCK_BIT];
      end
      // Single cycle pulse, accepts never come back to back
      rst_req_q <= req_fire && req_i.write &&
                   req_i.addr == mci_reg_pkg::ADDR_RESET_REQ &&
                   req_i.wdata[mci_reg_pkg::RESET_REQ_BIT];
    end
  end

  // Outputs
  assign req_ready_o   = req_ready_q;
  assign rsp_valid_o   = rsp_valid_q;
  assign rsp_o         = rsp_q;
  assign region_lock_o = region_lock_q;
  assign rst_req_o     = rst_req_q;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Stalled response keeps its payload
  a_rsp_stable: assert property (@(posedge clk) disable iff (!mci_rst_b)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else $error("response changed under back-pressure");

  // Sequencer sees each request exactly once
  a_rst_req_pulse: assert property (@(posedge clk) disable iff (!mci_rst_b)
    rst_req_o |=> !rst_req_o)
    else $error("rst_req held longer than one cycle");

endmodule

`default_nettype wire

// ==== source/mci_boot_top.sv ====
`default_nettype none

module mci_boot_top (
  input  logic                  clk,
  input  logic                  mci_rst_b,

  // Register bus
  input  logic                  req_valid_i,
  input  mci_reg_pkg::reg_req_t req_i,
  output logic                  req_ready_o,
  output logic                  rsp_valid_o,
  output mci_reg_pkg::reg_rsp_t rsp_o,
  input  logic                  rsp_ready_i,

  // Fuse and lifecycle controllers
  output logic                  fc_init_o,
  input  logic                  fc_done_i,
  output logic                  lc_init_o,
  input  logic                  lc_done_i,

  // Debug hold and core boot request
  input  logic                  brkpoint_i,
  input  logic                  cptra_boot_go_i,

  // Reset releases
  output logic                  mcu_rst_b_o,
  output logic                  cptra_rst_b_o
);

  // Register block to sequencer
  logic region_lock;
  logic rst_req;

  // Sequencer to register block
  mci_boot_pkg::boot_status_t status;

  ////////////////////////////////////////////////////////////
  // Register block
  ////////////////////////////////////////////////////////////

  mci_boot_regs regs0 (
    .clk           (clk),
    .mci_rst_b     (mci_rst_b),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_ready_o   (req_ready_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o),
    .rsp_ready_i   (rsp_ready_i),
    .status_i      (status),
    .region_lock_o (region_lock),
    .rst_req_o     (rst_req)
  );

  ////////////////////////////////////////////////////////////
  // Boot sequencer
  ////////////////////////////////////////////////////////////

  mci_boot_seqr #(
    .RST_CNT_W (mci_boot_pkg::MIN_RST_CNT_W)
  ) seqr0 (
    .clk             (clk),
    .mci_rst_b       (mci_rst_b),
    .fc_done_i       (fc_done_i),
    .lc_done_i       (lc_done_i),
    .brkpoint_i      (brkpoint_i),
    .cptra_boot_go_i (cptra_boot_go_i),
    .rst_req_i       (rst_req),
    .region_lock_i   (region_lock),
    .fc_init_o       (fc_init_o),
    .lc_init_o       (lc_init_o),
    .mcu_rst_b_o     (mcu_rst_b_o),
    .cptra_rst_b_o   (cptra_rst_b_o),
    .status_o        (status)
  );

endmodule

`default_nettype wire

// ==== bench/mci_boot_soc_model.sv ====
`default_nettype none

// Stands in for the fuse and lifecycle controllers
module mci_boot_soc_model (
  input  logic clk,
  input  logic fc_init_i,
  input  logic lc_init_i,
  output logic fc_done_o,
  output logic lc_done_o
);

  timeunit 1ns;
  timeprecision 100ps;

  integer seed;
  int     delay;

  initial begin
    seed      = 32'he0c8;
    fc_done_o = 1'b0;
    lc_done_o = 1'b0;

    ////////////////////////////////////////////////////////////
    // Fuse controller
    ////////////////////////////////////////////////////////////

    // Init is stable mid-cycle
    while (fc_init_i !== 1'b1) begin
      @(negedge clk);
    end
    delay = 2 + ($unsigned($random(seed)) % 16);
    repeat (delay) @(posedge clk);
    #1 fc_done_o = 1'b1;

    ////////////////////////////////////////////////////////////
    // Lifecycle controller
    ////////////////////////////////////////////////////////////

    while (lc_init_i !== 1'b1) begin
      @(negedge clk);
    end
    delay = 2 + ($unsigned($random(seed)) % 16);
    repeat (delay) @(posedge clk);
    // Done stays high for the rest of the run
    #1 lc_done_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== bench/mci_boot_tb.sv ====
`default_nettype none

module mci_boot_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 10;
  localparam int PHASE_CYCLES = 200;
  localparam int NUM_PHASES   = 6;

  logic clk;
  logic mci_rst_b;
  logic req_valid_i;
  mci_reg_pkg::reg_req_t req_i;
  logic req_ready_o;
  logic rsp_valid_o;
  mci_reg_pkg::reg_rsp_t rsp_o;
  logic rsp_ready_i;
  logic fc_init_o;
  logic fc_done_i;
  logic lc_init_o;
  logic lc_done_i;
  logic brkpoint_i;
  logic cptra_boot_go_i;
  logic mcu_rst_b_o;
  logic cptra_rst_b_o;

  integer seed;
  int     errors;
  int     checks;
  int     outstanding;
  int     low_len;
  int     brk_wait;
  logic   fc_seen;
  logic   lock_val;

  // Expected payload of the next response
  logic [31:0] exp_rdata;
  logic        exp_err;

  mci_boot_top dut0 (
    .clk             (clk),
    .mci_rst_b       (mci_rst_b),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .req_ready_o     (req_ready_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_o           (rsp_o),
    .rsp_ready_i     (rsp_ready_i),
    .fc_init_o       (fc_init_o),
    .fc_done_i       (fc_done_i),
    .lc_init_o       (lc_init_o),
    .lc_done_i       (lc_done_i),
    .brkpoint_i      (brkpoint_i),
    .cptra_boot_go_i (cptra_boot_go_i),
    .mcu_rst_b_o     (mcu_rst_b_o),
    .cptra_rst_b_o   (cptra_rst_b_o)
  );

  mci_boot_soc_model soc0 (
    .clk       (clk),
    .fc_init_i (fc_init_o),
    .lc_init_i (lc_init_o),
    .fc_done_o (fc_done_i),
    .lc_done_o (lc_done_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Bookkeeping for the checks
  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      outstanding <= 0;
      fc_seen     <= 1'b0;
      low_len     <= 0;
      brk_wait    <= 0;
    end else begin
      if (fc_done_i) begin
        fc_seen <= 1'b1;
      end
      if (req_valid_i && req_ready_o && !(rsp_valid_o && rsp_ready_i)) begin
        outstanding <= outstanding + 1;
      end else if (!(req_valid_i && req_ready_o) && rsp_valid_o && rsp_ready_i) begin
        outstanding <= outstanding - 1;
      end
      // Length of the current MCU reset
      if (mcu_rst_b_o) begin
        low_len <= 0;
      end else begin
        low_len <= low_len + 1;
      end
      // Cycles since the breakpoint dropped, first boot only
      if (brkpoint_i || mcu_rst_b_o || cptra_rst_b_o) begin
        brk_wait <= 0;
      end else begin
        brk_wait <= brk_wait + 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Boot order
  c_lc_after_fc: assert property (@(posedge clk) disable iff (!mci_rst_b)
    lc_init_o |-> fc_seen && fc_init_o)
    else begin errors++; $display("** Error %0t: lc_init before fc_done", $time); end
  c_mcu_after_lc: assert property (@(posedge clk) disable iff (!mci_rst_b)
    $rose(mcu_rst_b_o) |-> lc_done_i)
    else begin errors++; $display("** Error %0t: MCU released before lc_done", $time); end
  c_cptra_order: assert property (@(posedge clk) disable iff (!mci_rst_b)
    $rose(cptra_rst_b_o) |-> cptra_boot_go_i && mcu_rst_b_o)
    else begin errors++; $display("** Error %0t: core released out of order", $time); end

  // Breakpoint hold and release
  c_brk_hold: assert property (@(posedge clk) disable iff (!mci_rst_b)
    brkpoint_i && lc_done_i |-> !mcu_rst_b_o)
    else begin errors++; $display("** Error %0t: MCU released at breakpoint", $time); end
  c_brk_release: assert property (@(posedge clk) disable iff (!mci_rst_b)
    !brkpoint_i && !mcu_rst_b_o && !cptra_rst_b_o |-> brk_wait < 5)
    else begin errors++; $display("** Error %0t: MCU not released after breakpoint", $time); end

  // Minimum hold and region lock
  c_min_hold: assert property (@(posedge clk) disable iff (!mci_rst_b)
    $rose(mcu_rst_b_o) && cptra_rst_b_o |-> low_len >= 16)
    else begin errors++; $display("** Error %0t: MCU reset shorter than 16 cycles", $time); end
  c_lock_gate: assert property (@(posedge clk) disable iff (!mci_rst_b)
    $rose(mcu_rst_b_o) |-> lock_val || !cptra_rst_b_o)
    else begin errors++; $display("** Error %0t: MCU released with region unlocked", $time); end

  // Response payload against the register map
  c_rsp_data: assert property (@(posedge clk) disable iff (!mci_rst_b)
    rsp_valid_o && rsp_ready_i |-> rsp_o.rdata == exp_rdata && rsp_o.err == exp_err)
    else begin
      errors++;
      $display("** Error %0t: rsp rdata %h err %b, expected %h err %b",
               $time, rsp_o.rdata, rsp_o.err, exp_rdata, exp_err);
    end

  // Back-pressure and ordering
  c_rsp_hold: assert property (@(posedge clk) disable iff (!mci_rst_b)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else begin errors++; $display("** Error %0t: stalled response changed", $time); end
  c_no_accept: assert property (@(posedge clk) disable iff (!mci_rst_b)
    rsp_valid_o |-> !req_ready_o)
    else begin errors++; $display("** Error %0t: request ready with response pending", $time); end
  c_one_rsp: assert property (@(posedge clk) disable iff (!mci_rst_b)
    rsp_valid_o && rsp_ready_i |-> outstanding == 1)
    else begin errors++; $display("** Error %0t: response without request", $time); end
  c_one_req: assert property (@(posedge clk) disable iff (!mci_rst_b)
    req_valid_i && req_ready_o |-> outstanding == 0)
    else begin errors++; $display("** Error %0t: second request accepted", $time); end

  ////////////////////////////////////////////////////////////
  // Bus and wait tasks
  ////////////////////////////////////////////////////////////

  // One request and its response, with random response stall
  task automatic bus_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            input logic [31:0] rdata_exp, input logic err_exp);
    logic accepted;
    int   stall;
    begin
      exp_rdata   = rdata_exp;
      exp_err     = err_exp;
      req_i.write = wr;
      req_i.addr  = addr;
      req_i.wdata = wdata;
      req_valid_i = 1'b1;
      do begin
        @(negedge clk);
        accepted = req_ready_o;
        @(posedge clk);
      end while (!accepted);
      #1 req_valid_i = 1'b0;
      if (wr && addr == mci_reg_pkg::ADDR_FW_EXEC_CTRL) begin
        lock_val = wdata[0];
      end
      stall = $unsigned($random(seed)) % 4;
      repeat (stall) @(posedge clk);
      #1 rsp_ready_i = 1'b1;
      do begin
        @(negedge clk);
        accepted = rsp_valid_o;
        @(posedge clk);
      end while (!accepted);
      #1 rsp_ready_i = 1'b0;
      checks++;
    end
  endtask

  // Poll the MCU reset mid-cycle, return just after the next rising edge
  task automatic wait_mcu_rst(input logic level);
    begin
      while (mcu_rst_b_o !== level) begin
        @(negedge clk);
      end
      @(posedge clk);
      #1;
    end
  endtask

  // Firmware reset with the region unlocked for a while
  task automatic mcu_fw_reset(input int unlocked_cycles);
    begin
      bus_access(1'b1, mci_reg_pkg::ADDR_FW_EXEC_CTRL, 32'h0, 32'h0, 1'b0);
      bus_access(1'b1, mci_reg_pkg::ADDR_RESET_REQ, 32'h1, 32'h0, 1'b0);
      wait_mcu_rst(1'b0);
      repeat (unlocked_cycles) @(posedge clk);
      #1;
      bus_access(1'b1, mci_reg_pkg::ADDR_FW_EXEC_CTRL, 32'h1, 32'h0, 1'b0);
      wait_mcu_rst(1'b1);
    end
  endtask

  // Watchdog
  initial begin
    #(PHASE_CYCLES * NUM_PHASES * CLK_PERIOD);
    $display("Timeout: the run did not complete in %0d cycles", PHASE_CYCLES * NUM_PHASES);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    seed            = 32'he0c8;
    errors          = 0;
    checks          = 0;
    lock_val        = 1'b0;
    exp_rdata       = '0;
    exp_err         = 1'b0;
    mci_rst_b       = 1'b0;
    req_valid_i     = 1'b0;
    req_i           = '0;
    rsp_ready_i     = 1'b0;
    brkpoint_i      = 1'b1;
    cptra_boot_go_i = 1'b0;
    repeat (10) @(posedge clk);
    #1 mci_rst_b = 1'b1;

    // Boot up to the breakpoint, then release it
    wait (lc_done_i === 1'b1);
    repeat (10) @(posedge clk);
    #1 brkpoint_i = 1'b0;
    wait_mcu_rst(1'b1);
    repeat (2) @(posedge clk);
    #1 cptra_boot_go_i = 1'b1;
    wait (cptra_rst_b_o === 1'b1);
    @(posedge clk);
    #1;

    // Register map
    bus_access(1'b1, mci_reg_pkg::ADDR_FW_EXEC_CTRL, 32'h1, 32'h0, 1'b0);
    bus_access(1'b0, mci_reg_pkg::ADDR_FW_EXEC_CTRL, 32'h0, 32'h1, 1'b0);
    bus_access(1'b0, mci_reg_pkg::ADDR_RESET_REQ, 32'h0, 32'h0, 1'b0);
    bus_access(1'b0, 4'hC, 32'h0, 32'h0, 1'b1);
    bus_access(1'b1, 4'h2, 32'h0, 32'h0, 1'b1);
    bus_access(1'b0, mci_reg_pkg::ADDR_FW_EXEC_CTRL, 32'h0, 32'h1, 1'b0);
    bus_access(1'b1, mci_reg_pkg::ADDR_FW_EXEC_CTRL, 32'h0, 32'h0, 1'b0);
    bus_access(1'b0, mci_reg_pkg::ADDR_FW_EXEC_CTRL, 32'h0, 32'h0, 1'b0);
    bus_access(1'b0, mci_reg_pkg::ADDR_BOOT_STATUS, 32'h0, 32'h7, 1'b0);

    // First firmware reset is a boot update, held by the region lock
    mcu_fw_reset(30);
    bus_access(1'b0, mci_reg_pkg::ADDR_BOOT_STATUS, 32'h0, 32'h37, 1'b0);

    // Later ones are hitless, held by the minimum reset timer
    mcu_fw_reset(1);
    bus_access(1'b0, mci_reg_pkg::ADDR_BOOT_STATUS, 32'h0, 32'h57, 1'b0);

    repeat (5) @(posedge clk);
    $display("Bus transfers: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mci_boot.f ====
source/mci_boot_pkg.sv
source/mci_reg_pkg.sv
source/mci_boot_seqr.sv
source/mci_boot_regs.sv
source/mci_boot_top.sv
bench/mci_boot_soc_model.sv
bench/mci_boot_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the boot sequencer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module mci_boot_tb -f mci_boot.f

# The log decides the result, not the simulator exit status
obj_dir/Vmci_boot_tb 2>&1 | tee sim.log

if grep -q "^Finished with no errors$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
